// ==== rtl/tnn_pkg.sv ====
`default_nettype none

package tnn_pkg;

    //////////////////////////////
    // Network dimensions
    //////////////////////////////

    localparam int FEAT_CNT   = 11;
    localparam int FEAT_BITS  = 4;
    localparam int FEATURES_W = FEAT_CNT * FEAT_BITS;      // Packed feature word
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 7;

    //////////////////////////////
    // Derived widths
    //////////////////////////////

    localparam int SUM_BITS   = $clog2(HIDDEN_CNT + 1);    // Popcount up to 40
    localparam int SCORE_BITS = SUM_BITS + 1;              // Doubled count plus bias
    localparam int CLASS_BITS = $clog2(CLASS_CNT);

    // Signed neuron sum, holds +/- FEAT_CNT * 15
    localparam int ACC_BITS   = $clog2(FEAT_CNT * (2 ** FEAT_BITS - 1) + 1) + 1;

endpackage

`default_nettype wire

// ==== rtl/argmax.sv ====
`timescale 1ns/1ns
`default_nettype none

module argmax #(
    parameter int SIZE = 7,
    parameter int BITS = 7
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic [SIZE*BITS-1:0]     score_vec,
    input  wire logic                     score_valid,
    output logic      [$clog2(SIZE)-1:0]  prediction,
    output logic                          prediction_valid
);

    logic [BITS-1:0]         best_val;
    logic [$clog2(SIZE)-1:0] best_idx;

    //////////////////////////////
    // Linear scan
    //////////////////////////////

    always_comb begin
        best_val = score_vec[0 +: BITS];
        best_idx = '0;
        for (int i = 1; i < SIZE; i++) begin
            // Strict compare keeps the first maximum
            if (score_vec[i*BITS +: BITS] > best_val) begin
                best_val = score_vec[i*BITS +: BITS];
                best_idx = i[$clog2(SIZE)-1:0];
            end
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prediction       <= '0;
            prediction_valid <= 1'b0;
        end else begin
            prediction       <= best_idx;                      // Loaded every cycle
            prediction_valid <= score_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tnn_hidden_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tnn_hidden_layer (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic [tnn_pkg::FEATURES_W-1:0]    features,
    input  wire logic                              sample,
    output logic      [tnn_pkg::HIDDEN_CNT-1:0]    hidden,
    output logic                                   hidden_valid
);

    logic signed [tnn_pkg::ACC_BITS-1:0] f   [tnn_pkg::FEAT_CNT];
    logic signed [tnn_pkg::ACC_BITS-1:0] sum [tnn_pkg::HIDDEN_CNT];
    logic        [tnn_pkg::HIDDEN_CNT-1:0] fire;

    //////////////////////////////
    // Feature slicing
    //////////////////////////////

    for (genvar i = 0; i < tnn_pkg::FEAT_CNT; i++) begin : g_feat
        assign f[i] = {{(tnn_pkg::ACC_BITS - tnn_pkg::FEAT_BITS){1'b0}},
                       features[i*tnn_pkg::FEAT_BITS +: tnn_pkg::FEAT_BITS]};   // Zero extend
    end

    //////////////////////////////
    // Ternary neuron sums
    //////////////////////////////

    assign sum[0]  = -f[0] - f[1] + f[4] + f[7] - f[8] - f[9];
    assign sum[1]  = f[2] + f[3] + f[4] + f[6] + f[7] + f[9] + f[10];
    assign sum[2]  = f[2] - f[4] - f[5] - f[6] - f[7] + f[8] + f[9] + f[10];
    assign sum[3]  = f[0] - f[1] - f[4] + f[5] - f[6] - f[7];
    assign sum[4]  = -f[0] - f[1] + f[3] - f[4] + f[5] + f[9] + f[10];
    assign sum[5]  = -f[2] - f[3] + f[6] - f[7];
    assign sum[6]  = f[1] + f[2] + f[3] + f[4] + f[6] + f[7] - f[9];
    assign sum[7]  = f[0] + f[1] - f[4] - f[5] - f[6] - f[7] - f[10];

    assign sum[8]  = -f[0] + f[1] + f[2] - f[5] + f[6] - f[8] - f[9];
    assign sum[9]  = -f[0] - f[3] + f[4] + f[6] + f[7] - f[8] + f[10];
    assign sum[10] = f[3] + f[5] + f[6] - f[7];
    assign sum[11] = f[1] + f[2] + f[4] - f[5] + f[6] + f[8] - f[9] - f[10];
    assign sum[12] = f[1] + f[2] + f[5] + f[7] - f[9] - f[10];
    assign sum[13] = f[2] + f[4] - f[5] + f[8] - f[10];
    assign sum[14] = f[1] + f[2] + f[3] - f[4] - f[6] - f[7] + f[9] - f[10];
    assign sum[15] = -f[3] + f[6] - f[7] - f[8];

    assign sum[16] = f[1] + f[2] + f[3] + f[4] + f[5] + f[6] + f[7] + f[9] + f[10];
    assign sum[17] = f[0] - f[1] - f[4] + f[5] - f[7] - f[8];
    assign sum[18] = f[1] + f[2] + f[3] + f[6] + f[7] - f[8] - f[10];
    assign sum[19] = f[1] - f[2] - f[3] - f[4] - f[5] + f[6] - f[9];
    assign sum[20] = f[0] + f[1] - f[4] + f[5] - f[6] - f[7] + f[10];
    assign sum[21] = f[0] + f[1] - f[3] + f[7] + f[8] - f[9] - f[10];
    assign sum[22] = f[0] + f[1] + f[2] - f[3] - f[5] - f[6] + f[8] + f[10];
    assign sum[23] = f[1] + f[2] + f[4] + f[5] + f[6] + f[7] + f[8] + f[10];

    assign sum[24] = f[0] + f[1] + f[2] - f[3] - f[5] + f[6] - f[7] - f[10];
    assign sum[25] = -f[1] + f[3] - f[4] - f[7] + f[10];
    assign sum[26] = -f[2] - f[3] - f[10];
    assign sum[27] = -f[2] + f[3] + f[4] + f[6] + f[9];
    assign sum[28] = -f[10];                                   // Fires only on zero
    assign sum[29] = f[0] - f[1] - f[2] - f[3] + f[5] - f[7] - f[8] - f[9] + f[10];
    assign sum[30] = -f[1] + f[3] + f[4] + f[5] + f[7] + f[9];
    assign sum[31] = -f[0] - f[1] + f[5] + f[7] + f[10];

    assign sum[32] = f[1] + f[2] + f[3] + f[4] + f[7];
    assign sum[33] = f[1] + f[5] + f[7];
    assign sum[34] = -f[1] - f[2] + f[3] + f[4] + f[5] - f[6];
    assign sum[35] = f[0] + f[1] + f[2] - f[3] - f[4] + f[6] - f[7] + f[8] + f[9];
    assign sum[36] = f[1] - f[2] - f[5] - f[6] - f[7] + f[9];
    assign sum[37] = f[1] - f[3] - f[4] - f[5] + f[6] - f[9];
    assign sum[38] = f[1] + f[2] - f[10];
    assign sum[39] = -f[0] - f[4] + f[5] + f[6] - f[7] - f[8] + f[10];

    // Sign bit clear means sum >= 0
    for (genvar n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin : g_fire
        assign fire[n] = ~sum[n][tnn_pkg::ACC_BITS-1];
    end

    //////////////////////////////
    // Stage 1 register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hidden       <= '0;
            hidden_valid <= 1'b0;
        end else begin
            hidden_valid <= sample;
            if (sample) begin
                hidden <= fire;                                // Hold between samples
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tnn_class_scores.sv ====
`timescale 1ns/1ns
`default_nettype none

module tnn_class_scores (
    input  wire logic                                               clk,
    input  wire logic                                               arst_n,
    input  wire logic [tnn_pkg::HIDDEN_CNT-1:0]                     hidden,
    input  wire logic                                               hidden_valid,
    output logic [tnn_pkg::CLASS_CNT*tnn_pkg::SCORE_BITS-1:0]       score_vec,
    output logic                                                    score_valid,
    output logic [tnn_pkg::CLASS_BITS-1:0]                          prediction,
    output logic                                                    prediction_valid
);

    logic [tnn_pkg::SUM_BITS-1:0]   h        [tnn_pkg::HIDDEN_CNT];
    logic [tnn_pkg::SUM_BITS-1:0]   hn       [tnn_pkg::HIDDEN_CNT];
    logic [tnn_pkg::SUM_BITS-1:0]   popcount [tnn_pkg::CLASS_CNT];
    logic [tnn_pkg::SCORE_BITS-1:0] score    [tnn_pkg::CLASS_CNT];

    function automatic logic [tnn_pkg::SCORE_BITS-1:0] class_score(
        input logic [tnn_pkg::SUM_BITS-1:0]   cnt,
        input logic [tnn_pkg::SCORE_BITS-1:0] bias
    );
        class_score = {cnt, 1'b0} + bias;                     // 2 * cnt + bias
    endfunction

    for (genvar j = 0; j < tnn_pkg::HIDDEN_CNT; j++) begin : g_ext
        assign h[j]  = {{(tnn_pkg::SUM_BITS-1){1'b0}}, hidden[j]};
        assign hn[j] = {{(tnn_pkg::SUM_BITS-1){1'b0}}, ~hidden[j]};
    end

    //////////////////////////////
    // Per-class popcounts
    //////////////////////////////

    assign popcount[0] = hn[1] + h[4] + hn[6] + h[7] + hn[9] + hn[10] + h[11] + h[15]
                       + hn[16] + h[18] + h[20] + hn[23] + h[28] + hn[38];
    assign popcount[1] = h[7] + hn[10] + h[11] + hn[16] + h[19] + h[20] + h[22] + hn[23]
                       + h[24] + h[28] + hn[30] + hn[31] + hn[34] + h[37] + h[38];
    assign popcount[2] = hn[9] + h[18] + h[20] + h[24] + hn[25] + hn[33] + h[36] + h[37];
    assign popcount[3] = h[1] + h[15] + h[16] + h[23] + h[24] + h[31] + hn[33] + h[37];
    assign popcount[4] = hn[8] + hn[12] + hn[16] + hn[21] + h[22] + h[28] + hn[33];
    assign popcount[5] = hn[11] + hn[13] + hn[16] + hn[23] + h[31] + hn[33];
    assign popcount[6] = hn[1] + hn[2] + h[4] + h[5] + hn[6] + hn[12] + h[13] + hn[16]
                       + hn[17] + h[18] + h[20] + hn[23] + h[24] + hn[27] + hn[30]
                       + hn[32] + hn[33] + hn[34] + hn[35] + h[37] + hn[38];

    assign score[0] = class_score(popcount[0], 7);
    assign score[1] = class_score(popcount[1], 6);
    assign score[2] = class_score(popcount[2], 13);
    assign score[3] = class_score(popcount[3], 13);
    assign score[4] = class_score(popcount[4], 14);
    assign score[5] = class_score(popcount[5], 15);
    assign score[6] = class_score(popcount[6], 0);

    for (genvar c = 0; c < tnn_pkg::CLASS_CNT; c++) begin : g_pack
        assign score_vec[c*tnn_pkg::SCORE_BITS +: tnn_pkg::SCORE_BITS] = score[c];
    end

    assign score_valid = hidden_valid;

    argmax #(
        .SIZE (tnn_pkg::CLASS_CNT),
        .BITS (tnn_pkg::SCORE_BITS)
    ) u_argmax (
        .clk              (clk),
        .arst_n           (arst_n),
        .score_vec        (score_vec),
        .score_valid      (score_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/tnn_classifier.sv ====
`timescale 1ns/1ns
`default_nettype none

module tnn_classifier (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic [tnn_pkg::FEATURES_W-1:0]    features,
    input  wire logic                              sample,
    output logic      [tnn_pkg::CLASS_BITS-1:0]    prediction,
    output logic                                   prediction_valid
);

    logic [tnn_pkg::HIDDEN_CNT-1:0] hidden;
    logic                           hidden_valid;

    //////////////////////////////
    // Stage 1
    //////////////////////////////

    tnn_hidden_layer u_hidden (
        .clk          (clk),
        .arst_n       (arst_n),
        .features     (features),
        .sample       (sample),
        .hidden       (hidden),
        .hidden_valid (hidden_valid)
    );

    //////////////////////////////
    // Stage 2
    //////////////////////////////

    // Score vector is internal to the class stage
    tnn_class_scores u_scores (
        .clk              (clk),
        .arst_n           (arst_n),
        .hidden           (hidden),
        .hidden_valid     (hidden_valid),
        .score_vec        (),
        .score_valid      (),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

endmodule

`default_nettype wire

// ==== tests/tnn_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tnn_checker (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic [tnn_pkg::FEATURES_W-1:0]    features,
    input  wire logic                              sample,
    input  wire logic [tnn_pkg::CLASS_BITS-1:0]    prediction,
    input  wire logic                              prediction_valid
);

    localparam int MAX_PATTERNS = 64;
    localparam int LATENCY      = 2;

    logic [8*24-1:0]                 exp_name  [MAX_PATTERNS];
    logic [tnn_pkg::FEATURES_W-1:0]  exp_feat  [MAX_PATTERNS];
    logic [tnn_pkg::CLASS_BITS-1:0]  exp_class [MAX_PATTERNS];
    int                              exp_cnt;

    int   pend_idx   [$];
    int   pend_cycle [$];
    int   cycle;
    int   err_cnt;
    int   ok_cnt;
    int   sample_cnt;
    int   pulse_cnt;
    int   pending_cnt;
    logic seen_sample;
    logic after_reset;

    //////////////////////////////
    // Expected values
    //////////////////////////////

    task automatic load_expected();
        int    fd;
        int    n;
        string line;
        logic [8*24-1:0]                nm;
        logic [tnn_pkg::FEATURES_W-1:0] word;
        logic [tnn_pkg::CLASS_BITS-1:0] cls;
        exp_cnt = 0;
        fd = $fopen("tests/tnn_patterns.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the pattern file");
            err_cnt++;
        end else begin
            while (!$feof(fd) && exp_cnt < MAX_PATTERNS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %d", nm, word, cls);
                    if (n == 3) begin
                        exp_name[exp_cnt]  = nm;
                        exp_feat[exp_cnt]  = word;
                        exp_class[exp_cnt] = cls;
                        exp_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int find_pattern(input logic [tnn_pkg::FEATURES_W-1:0] word);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_cnt; i++) begin
            if (idx < 0 && exp_feat[i] == word) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    initial begin
        err_cnt     = 0;
        ok_cnt      = 0;
        sample_cnt  = 0;
        pulse_cnt   = 0;
        pending_cnt = 0;
        cycle       = 0;
        seen_sample = 1'b0;
        after_reset = 1'b0;
        load_expected();
    end

    //////////////////////////////
    // Monitor
    //////////////////////////////

    always @(posedge clk) begin
        int idx;
        int lat;
        cycle = cycle + 1;                                     // Values seen are pre-edge
        if (!arst_n) begin
            after_reset = 1'b1;
        end else begin
            // First edge out of reset still shows the reset values
            if (after_reset && (prediction_valid || prediction != '0)) begin
                $display("prediction outputs were not cleared by reset");
                err_cnt++;
            end
            after_reset = 1'b0;
            if (!seen_sample && prediction_valid) begin
                $display("prediction_valid rose before the first sample");
                err_cnt++;
            end
            if (prediction_valid) begin
                pulse_cnt++;
                if (pend_idx.size() == 0) begin
                    $display("prediction_valid arrived with no sample pending");
                    err_cnt++;
                end else begin
                    idx = pend_idx.pop_front();
                    lat = cycle - pend_cycle.pop_front();
                    if (idx < 0) begin
                        $display("result arrived for a sample not in the pattern file");
                        err_cnt++;
                    end else if (lat != LATENCY) begin
                        $display("%0s result arrived after %0d cycles instead of %0d",
                                 exp_name[idx], lat, LATENCY);
                        err_cnt++;
                    end else if (prediction != exp_class[idx]) begin
                        $display("ERR %0s expected %0d actual %0d",
                                 exp_name[idx], exp_class[idx], prediction);
                        err_cnt++;
                    end else begin
                        $display("%0s ok", exp_name[idx]);
                        ok_cnt++;
                    end
                end
            end
            if (sample) begin
                seen_sample = 1'b1;
                sample_cnt++;
                pend_idx.push_back(find_pattern(features));
                pend_cycle.push_back(cycle);
            end
            pending_cnt = pend_idx.size();
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_tnn_classifier.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tnn_classifier;

    localparam int MAX_PATTERNS   = 64;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int SEED           = 62979;

    logic                             clk;
    logic                             arst_n;
    logic [tnn_pkg::FEATURES_W-1:0]   features;
    logic                             sample;
    logic [tnn_pkg::CLASS_BITS-1:0]   prediction;
    logic                             prediction_valid;

    logic [tnn_pkg::FEATURES_W-1:0]   pat_feat [MAX_PATTERNS];
    int                               pat_cnt;
    int                               sent_cnt;
    int                               fail_cnt;
    logic                             timed_out;

    tnn_classifier DUT (
        .clk              (clk),
        .arst_n           (arst_n),
        .features         (features),
        .sample           (sample),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

    tnn_checker u_checker (
        .clk              (clk),
        .arst_n           (arst_n),
        .features         (features),
        .sample           (sample),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                                // 20 ns period
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        logic [8*24-1:0]                nm;
        logic [tnn_pkg::FEATURES_W-1:0] word;
        logic [tnn_pkg::CLASS_BITS-1:0] cls;
        pat_cnt = 0;
        fd = $fopen("tests/tnn_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/tnn_patterns.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd) && pat_cnt < MAX_PATTERNS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %d", nm, word, cls);
                    if (n == 3) begin
                        pat_feat[pat_cnt] = word;
                        pat_cnt++;
                    end
                end
            end
            $fclose(fd);
            if (pat_cnt == 0) begin
                $display("pattern file holds no usable lines");
                fail_cnt++;
            end
        end
    endtask

    task automatic drive_sample(input logic [tnn_pkg::FEATURES_W-1:0] word);
        @(posedge clk);
        #2;
        features = word;
        sample   = 1'b1;
        sent_cnt++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        sample = 1'b0;
    endtask

    task automatic wait_for_results(input int target);
        int waited;
        waited = 0;
        while (u_checker.pulse_cnt < target && !timed_out) begin
            @(posedge clk);
            #1;                                                // Let the checker count first
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("timeout waiting for prediction_valid");
                timed_out = 1'b1;
            end
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    task automatic run_tests();
        int gap;
        repeat (4) @(posedge clk);                             // Reset held 4 cycles
        #2;
        arst_n = 1'b1;
        repeat (5) drive_idle();                               // Quiet after reset

        // Isolated samples
        for (int i = 0; i < pat_cnt && !timed_out; i++) begin
            gap = $urandom_range(4, 1);
            repeat (gap) drive_idle();
            drive_sample(pat_feat[i]);
            drive_idle();
            wait_for_results(sent_cnt);
        end

        // Back-to-back samples
        if (!timed_out) begin
            for (int i = 0; i < pat_cnt; i++) begin
                drive_sample(pat_feat[i]);
            end
            drive_idle();
            wait_for_results(sent_cnt);
        end
        repeat (4) drive_idle();
    endtask

    task automatic report_results();
        if (u_checker.pulse_cnt != u_checker.sample_cnt) begin
            $display("saw %0d results for %0d samples",
                     u_checker.pulse_cnt, u_checker.sample_cnt);
            fail_cnt++;
        end
        if (u_checker.pending_cnt != 0) begin
            $display("checker queue still holds %0d entries", u_checker.pending_cnt);
            fail_cnt++;
        end
        if (u_checker.ok_cnt != 2 * pat_cnt) begin
            $display("only %0d of %0d tests passed", u_checker.ok_cnt, 2 * pat_cnt);
            fail_cnt++;
        end
        $display("tests %0d ok %0d errors %0d samples %0d results %0d",
                 2 * pat_cnt, u_checker.ok_cnt, u_checker.err_cnt + fail_cnt,
                 u_checker.sample_cnt, u_checker.pulse_cnt);
        if (timed_out || fail_cnt != 0 || u_checker.err_cnt != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        sample    = 1'b0;
        features  = '0;
        sent_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));
        load_patterns();
        if (fail_cnt == 0) begin
            run_tests();
        end
        report_results();
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tnn_patterns.txt ====
# name  features (f10 in top hex digit, f0 in bottom)  expected class
# one test per line, class is the argmax with lowest index on ties
zero_all     00000000000 3
ones_all     FFFFFFFFFFF 3
ones_mid     55555555555 3
ones_one     11111111111 3
f0_max       0000000000F 1
f1_max       000000000F0 1
f2_max       00000000F00 3
tie_f3_max   0000000F000 0
f4_max       000000F0000 3
f5_max       00000F00000 3
f6_max       0000F000000 3
f7_max       000F0000000 3
f8_max       00F00000000 3
f9_max       0F000000000 3
f10_max      F0000000000 3
f0_low       00000000001 1
f1_mid       00000000070 1
f2_low       00000000100 3
tie_f3_low   00000001000 0
tie_f3_mid   00000008000 0
f5_mid       00000A00000 3
f9_low       01000000000 3
f10_mid      90000000000 3

// ==== sim.f ====
rtl/tnn_pkg.sv
rtl/argmax.sv
rtl/tnn_hidden_layer.sv
rtl/tnn_class_scores.sv
rtl/tnn_classifier.sv
tests/tnn_checker.sv
tests/tb_tnn_classifier.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing -f sim.f --top-module tb_tnn_classifier -o tb_tnn_classifier

./obj_dir/tb_tnn_classifier > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
